//--- logic/video_timing_pkg.sv
// scan timing defaults and the screen coordinate type for the display engine
package video_timing_pkg;

  // screen coordinate, counts up to 1023
  typedef logic [9:0] coord_t;

  // horizontal timing in pixel clocks
  // 640 visible out of 800 per line
  localparam int H_VISIBLE_DEF    = 640;
  // front porch of 16, then 96 of sync
  localparam int H_SYNC_START_DEF = 656;
  localparam int H_SYNC_END_DEF   = 752;
  localparam int H_TOTAL_DEF      = 800;

  // vertical timing in lines
  // 480 visible out of 525 per frame
  localparam int V_VISIBLE_DEF    = 480;
  // front porch of 10, then 2 lines of sync
  localparam int V_SYNC_START_DEF = 490;
  localparam int V_SYNC_END_DEF   = 492;
  localparam int V_TOTAL_DEF      = 525;

endpackage

//--- logic/fb_mem_pkg.sv
// frame buffer memory word, address and region definitions with default geometry
package fb_mem_pkg;

  // one word address on the external memory bus
  typedef logic [23:0] mem_addr_t;

  // colour view of a word, one bit per gun
  // blue gets two bits so it is split
  typedef struct packed {
    logic red;
    logic green;
    logic blue_hi;
    logic blue_lo;
  } color_t;

  // a stored word, pixel colour in the buffers and depth in the depth region
  // depth is an unsigned fraction, all ones is farthest
  typedef union packed {
    color_t     color;
    logic [3:0] depth;
  } mem_word_u;

  // which region of memory an access targets
  typedef logic [1:0] region_t;

  localparam region_t RGN_BUF0  = 2'd0;
  localparam region_t RGN_BUF1  = 2'd1;
  localparam region_t RGN_DEPTH = 2'd2;

  // clear values
  localparam color_t     COLOR_BLACK = '0;
  localparam logic [3:0] DEPTH_FAR   = 4'hF;

  // default buffer size in words, quarter of the visible area
  localparam int FB_W_DEF = 320;
  localparam int FB_H_DEF = 240;

endpackage

//--- logic/scan_timer.sv
// raster scan counters with sync pulses and a frame start strobe
`timescale 1ns/1ps

module scan_timer #(
  parameter int H_SYNC_START = video_timing_pkg::H_SYNC_START_DEF,
  parameter int H_SYNC_END   = video_timing_pkg::H_SYNC_END_DEF,
  parameter int H_TOTAL      = video_timing_pkg::H_TOTAL_DEF,
  parameter int V_SYNC_START = video_timing_pkg::V_SYNC_START_DEF,
  parameter int V_SYNC_END   = video_timing_pkg::V_SYNC_END_DEF,
  parameter int V_TOTAL      = video_timing_pkg::V_TOTAL_DEF
) (
  input  logic                     clk,
  input  logic                     rst_n,
  output video_timing_pkg::coord_t o_x,
  output video_timing_pkg::coord_t o_y,
  output logic                     o_hsync,
  output logic                     o_vsync,
  output logic                     o_frame_start
);

  import video_timing_pkg::*;

  logic line_end;
  logic frame_end;

  // last pixel of a line, last line of a frame
  assign line_end  = (o_x == coord_t'(H_TOTAL - 1));
  assign frame_end = (o_y == coord_t'(V_TOTAL - 1));

  // one step per clock, x wraps into the next line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_x <= '0;
      o_y <= '0;
    end else if (line_end) begin
      o_x <= '0;
      // vertical wrap only at the end of the last line
      if (frame_end) begin
        o_y <= '0;
      end else begin
        o_y <= o_y + 1'b1;
      end
    end else begin
      o_x <= o_x + 1'b1;
    end
  end

  // syncs are active low inside their windows
  assign o_hsync = !((o_x >= coord_t'(H_SYNC_START)) && (o_x < coord_t'(H_SYNC_END)));
  assign o_vsync = !((o_y >= coord_t'(V_SYNC_START)) && (o_y < coord_t'(V_SYNC_END)));

  // high for the single cycle at the top left corner
  assign o_frame_start = (o_x == '0) && (o_y == '0);

endmodule

//--- logic/scanout_reader.sv
// front buffer scanout with look-ahead reads and pixel alignment
`timescale 1ns/1ps

module scanout_reader #(
  parameter int FB_W       = fb_mem_pkg::FB_W_DEF,
  parameter int FB_H       = fb_mem_pkg::FB_H_DEF,
  parameter int H_VISIBLE  = video_timing_pkg::H_VISIBLE_DEF,
  parameter int V_VISIBLE  = video_timing_pkg::V_VISIBLE_DEF,
  parameter int H_TOTAL    = video_timing_pkg::H_TOTAL_DEF,
  parameter int V_TOTAL    = video_timing_pkg::V_TOTAL_DEF,
  parameter int RD_LATENCY = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  video_timing_pkg::coord_t  i_x,
  input  video_timing_pkg::coord_t  i_y,
  input  logic                      i_front_sel,
  input  fb_mem_pkg::mem_word_u     i_mem_rdata,
  output logic                      o_rd_req,
  output logic                      o_next_rd,
  output fb_mem_pkg::mem_addr_t     o_rd_addr,
  output logic [3:0]                o_pixel
);

  import video_timing_pkg::*;
  import fb_mem_pkg::*;

  // distance between the timer and the position being fetched
  localparam int        LOOK_AHEAD = RD_LATENCY + 1;
  localparam mem_addr_t BUF1_BASE  = mem_addr_t'(FB_W * FB_H);

  logic [10:0]         x_sum;
  coord_t              la_x;
  coord_t              la_y;
  logic                la_in_buf;
  mem_addr_t           front_base;
  // in-buffer flag per fetch in flight, bit 0 is the read on the bus
  logic [RD_LATENCY:0] flag_sr;

  // look-ahead position
  // past the line end it wraps into the next line, fetched during hblank
  always_comb begin
    x_sum = {1'b0, i_x} + 11'(LOOK_AHEAD);
    la_x  = x_sum[9:0];
    la_y  = i_y;
    if (x_sum >= 11'(H_TOTAL)) begin
      la_x = coord_t'(x_sum - 11'(H_TOTAL));
      // last line wraps to the top of the next frame
      la_y = (i_y == coord_t'(V_TOTAL - 1)) ? '0 : coord_t'(i_y + 1'b1);
    end
  end

  // buffer clipped to the visible area
  assign la_in_buf = (la_x < coord_t'(FB_W)) && (la_x < coord_t'(H_VISIBLE)) &&
                     (la_y < coord_t'(FB_H)) && (la_y < coord_t'(V_VISIBLE));

  assign front_base = i_front_sel ? BUF1_BASE : '0;

  // row major word address inside the front buffer
  always_ff @(posedge clk) begin
    o_rd_addr <= front_base + mem_addr_t'(la_y) * mem_addr_t'(FB_W) + mem_addr_t'(la_x);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_sr <= '0;
      o_pixel <= '0;
    end else begin
      flag_sr <= {flag_sr[RD_LATENCY-1:0], la_in_buf};
      // oldest flag lines up with the word now on the bus
      // positions without a fetch show black
      o_pixel <= flag_sr[RD_LATENCY] ? i_mem_rdata.color : COLOR_BLACK;
    end
  end

  // read goes out the cycle after the position is decided
  assign o_rd_req  = flag_sr[0];
  // what o_rd_req will be next cycle
  assign o_next_rd = la_in_buf;

endmodule

//--- logic/buffer_clearer.sv
// clears the new back buffer to black and the depth region to far after a swap
`timescale 1ns/1ps

module buffer_clearer #(
  parameter int FB_W = fb_mem_pkg::FB_W_DEF,
  parameter int FB_H = fb_mem_pkg::FB_H_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_start,
  input  logic                  i_front_sel,
  input  logic                  i_grant,
  output logic                  o_wr_req,
  output fb_mem_pkg::mem_addr_t o_addr,
  output fb_mem_pkg::mem_word_u o_data,
  output logic                  o_idle
);

  import fb_mem_pkg::*;

  localparam int        FB_WORDS   = FB_W * FB_H;
  localparam mem_addr_t LAST_WORD  = mem_addr_t'(FB_WORDS - 1);
  localparam mem_addr_t BUF1_BASE  = mem_addr_t'(FB_WORDS);
  localparam mem_addr_t DEPTH_BASE = mem_addr_t'(2 * FB_WORDS);

  // sequence states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_COLOR = 2'd1;
  localparam logic [1:0] ST_DEPTH = 2'd2;

  logic [1:0] state;
  mem_addr_t  cnt;
  logic       back_sel;
  region_t    rgn;
  mem_addr_t  base;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      back_sel <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            // front flips on this same edge
            // so the old front is the new back
            back_sel <= i_front_sel;
            cnt      <= '0;
            state    <= ST_COLOR;
          end
        end
        ST_COLOR: begin
          // advance only when the bus was ours
          if (i_grant) begin
            if (cnt == LAST_WORD) begin
              cnt   <= '0;
              state <= ST_DEPTH;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        ST_DEPTH: begin
          if (i_grant) begin
            if (cnt == LAST_WORD) begin
              cnt   <= '0;
              state <= ST_IDLE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // target region and its base
  always_comb begin
    if (state == ST_DEPTH) begin
      rgn = RGN_DEPTH;
    end else begin
      rgn = back_sel ? RGN_BUF1 : RGN_BUF0;
    end
    case (rgn)
      RGN_BUF1:  base = BUF1_BASE;
      RGN_DEPTH: base = DEPTH_BASE;
      default:   base = '0;
    endcase
  end

  // colour words in the buffer, far depth in the depth region
  always_comb begin
    if (state == ST_DEPTH) begin
      o_data.depth = DEPTH_FAR;
    end else begin
      o_data.color = COLOR_BLACK;
    end
  end

  // request held until granted
  assign o_wr_req = (state != ST_IDLE);
  assign o_addr   = base + cnt;
  assign o_idle   = (state == ST_IDLE);

endmodule

//--- logic/mem_arbiter.sv
// fixed priority arbiter for the memory bus with the render free window
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int FB_W = fb_mem_pkg::FB_W_DEF,
  parameter int FB_H = fb_mem_pkg::FB_H_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // scanout, always served
  input  logic                  i_rd_req,
  input  fb_mem_pkg::mem_addr_t i_rd_addr,
  input  logic                  i_next_rd,
  // clearer
  input  logic                  i_clr_req,
  input  fb_mem_pkg::mem_addr_t i_clr_addr,
  input  fb_mem_pkg::mem_word_u i_clr_data,
  input  logic                  i_clr_idle,
  // renderer
  input  logic                  i_rnd_wr,
  input  fb_mem_pkg::mem_addr_t i_rnd_addr,
  input  fb_mem_pkg::mem_word_u i_rnd_data,
  output logic                  o_clr_grant,
  output logic                  o_rnd_free,
  // external bus
  output logic                  o_mem_rd,
  output logic                  o_mem_wr,
  output fb_mem_pkg::mem_addr_t o_mem_addr,
  output fb_mem_pkg::mem_word_u o_mem_wdata
);

  import fb_mem_pkg::*;

  // buffers plus depth region, nothing above is ever written
  localparam mem_addr_t ADDR_LIMIT = mem_addr_t'(3 * FB_W * FB_H);

  logic rnd_ok;
  logic rnd_grant;

  // out of range render writes are dropped
  assign rnd_ok = i_rnd_wr && (i_rnd_addr < ADDR_LIMIT);

  // scanout, then clearer, then renderer
  assign o_clr_grant = i_clr_req && !i_rd_req;
  assign rnd_grant   = rnd_ok && !i_rd_req && !i_clr_req;

  assign o_mem_rd = i_rd_req;
  assign o_mem_wr = o_clr_grant || rnd_grant;

  always_comb begin
    if (i_rd_req) begin
      o_mem_addr = i_rd_addr;
    end else if (o_clr_grant) begin
      o_mem_addr = i_clr_addr;
    end else begin
      o_mem_addr = i_rnd_addr;
    end
  end

  assign o_mem_wdata = o_clr_grant ? i_clr_data : i_rnd_data;

  // free next cycle
  // no read now, none coming and the clearer has finished
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rnd_free <= 1'b0;
    end else begin
      o_rnd_free <= !i_rd_req && !i_next_rd && i_clr_idle;
    end
  end

endmodule

//--- logic/tinygpu_fb_top.sv
// display engine top with swap control, scanout, clearing and bus sharing
`timescale 1ns/1ps

module tinygpu_fb_top #(
  parameter int FB_W         = fb_mem_pkg::FB_W_DEF,
  parameter int FB_H         = fb_mem_pkg::FB_H_DEF,
  parameter int H_VISIBLE    = video_timing_pkg::H_VISIBLE_DEF,
  parameter int H_SYNC_START = video_timing_pkg::H_SYNC_START_DEF,
  parameter int H_SYNC_END   = video_timing_pkg::H_SYNC_END_DEF,
  parameter int H_TOTAL      = video_timing_pkg::H_TOTAL_DEF,
  parameter int V_VISIBLE    = video_timing_pkg::V_VISIBLE_DEF,
  parameter int V_SYNC_START = video_timing_pkg::V_SYNC_START_DEF,
  parameter int V_SYNC_END   = video_timing_pkg::V_SYNC_END_DEF,
  parameter int V_TOTAL      = video_timing_pkg::V_TOTAL_DEF,
  parameter int RD_LATENCY   = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_swap,
  input  logic                  i_rnd_wr,
  input  fb_mem_pkg::mem_addr_t i_rnd_addr,
  input  fb_mem_pkg::mem_word_u i_rnd_data,
  input  fb_mem_pkg::mem_word_u i_mem_rdata,
  output logic                  o_mem_rd,
  output logic                  o_mem_wr,
  output fb_mem_pkg::mem_addr_t o_mem_addr,
  output fb_mem_pkg::mem_word_u o_mem_wdata,
  output logic                  o_rnd_free,
  output logic                  o_hsync,
  output logic                  o_vsync,
  output logic [3:0]            o_pixel
);

  import video_timing_pkg::*;
  import fb_mem_pkg::*;

  coord_t    x;
  coord_t    y;
  logic      hsync_raw;
  logic      vsync_raw;
  logic      frame_start;
  logic      swap_pending;
  logic      front_sel;
  logic      rd_front;
  logic      clr_start;
  logic      rd_req;
  logic      next_rd;
  mem_addr_t rd_addr;
  logic      clr_req;
  mem_addr_t clr_addr;
  mem_word_u clr_data;
  logic      clr_grant;
  logic      clr_idle;

  scan_timer #(
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL)
  ) u_scan_timer (
    .clk           (clk),
    .rst_n         (rst_n),
    .o_x           (x),
    .o_y           (y),
    .o_hsync       (hsync_raw),
    .o_vsync       (vsync_raw),
    .o_frame_start (frame_start)
  );

  // swap request waits for the frame start, then flips the front
  // a swap arriving on that very cycle stays pending for the next frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      swap_pending <= 1'b0;
      front_sel    <= 1'b0;
    end else if (frame_start && swap_pending) begin
      front_sel    <= ~front_sel;
      swap_pending <= i_swap;
    end else if (i_swap) begin
      swap_pending <= 1'b1;
    end
  end

  assign clr_start = frame_start && swap_pending;

  // in the last line every in-buffer fetch belongs to the next frame
  // so it already reads the buffer that will be the front
  // as does the frame start cycle, whose flip only lands at its end
  assign rd_front = front_sel ^
                    (swap_pending && (frame_start || (y == coord_t'(V_TOTAL - 1))));

  scanout_reader #(
    .FB_W       (FB_W),
    .FB_H       (FB_H),
    .H_VISIBLE  (H_VISIBLE),
    .V_VISIBLE  (V_VISIBLE),
    .H_TOTAL    (H_TOTAL),
    .V_TOTAL    (V_TOTAL),
    .RD_LATENCY (RD_LATENCY)
  ) u_scanout_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_x         (x),
    .i_y         (y),
    .i_front_sel (rd_front),
    .i_mem_rdata (i_mem_rdata),
    .o_rd_req    (rd_req),
    .o_next_rd   (next_rd),
    .o_rd_addr   (rd_addr),
    .o_pixel     (o_pixel)
  );

  buffer_clearer #(
    .FB_W (FB_W),
    .FB_H (FB_H)
  ) u_buffer_clearer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (clr_start),
    .i_front_sel (front_sel),
    .i_grant     (clr_grant),
    .o_wr_req    (clr_req),
    .o_addr      (clr_addr),
    .o_data      (clr_data),
    .o_idle      (clr_idle)
  );

  mem_arbiter #(
    .FB_W (FB_W),
    .FB_H (FB_H)
  ) u_mem_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_rd_req    (rd_req),
    .i_rd_addr   (rd_addr),
    .i_next_rd   (next_rd),
    .i_clr_req   (clr_req),
    .i_clr_addr  (clr_addr),
    .i_clr_data  (clr_data),
    .i_clr_idle  (clr_idle),
    .i_rnd_wr    (i_rnd_wr),
    .i_rnd_addr  (i_rnd_addr),
    .i_rnd_data  (i_rnd_data),
    .o_clr_grant (clr_grant),
    .o_rnd_free  (o_rnd_free),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata)
  );

  // pixel register trails the timer by one position
  // one sync stage brings the syncs to the same position
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
    end else begin
      o_hsync <= hsync_raw;
      o_vsync <= vsync_raw;
    end
  end

endmodule

//--- tests/tinygpu_fb_chk.sv
// bound checker for memory bus exclusivity, write range and blanking of the pixel output
`timescale 1ns/1ps

module tinygpu_fb_chk #(
  parameter int FB_W = fb_mem_pkg::FB_W_DEF,
  parameter int FB_H = fb_mem_pkg::FB_H_DEF
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  i_mem_rd,
  input logic                  i_mem_wr,
  input fb_mem_pkg::mem_addr_t i_mem_addr,
  input logic                  i_hsync,
  input logic                  i_vsync,
  input logic [3:0]            i_pixel
);

  import fb_mem_pkg::*;

  // two buffers and the depth region
  localparam mem_addr_t ADDR_LIMIT = mem_addr_t'(3 * FB_W * FB_H);

  // one access per cycle on the bus
  a_rd_wr_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(i_mem_rd && i_mem_wr))
    else $error("memory read and write strobes high in the same cycle");

  // writes stay inside the three regions
  a_wr_range : assert property (@(posedge clk) disable iff (!rst_n)
    i_mem_wr |-> (i_mem_addr < ADDR_LIMIT))
    else $error("memory write address beyond the depth region");

  // black during either sync pulse
  a_sync_black : assert property (@(posedge clk) disable iff (!rst_n)
    (!i_hsync || !i_vsync) |-> (i_pixel == 4'h0))
    else $error("pixel not black while a sync is active");

endmodule

bind tinygpu_fb_top tinygpu_fb_chk #(
  .FB_W (FB_W),
  .FB_H (FB_H)
) u_tinygpu_fb_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .i_mem_rd   (o_mem_rd),
  .i_mem_wr   (o_mem_wr),
  .i_mem_addr (o_mem_addr),
  .i_hsync    (o_hsync),
  .i_vsync    (o_vsync),
  .i_pixel    (o_pixel)
);

//--- tests/tb_tinygpu_fb.sv
// testbench for the display engine with a latency memory model and a trace of checks
`timescale 1ns/1ps

module tb_tinygpu_fb;

  import fb_mem_pkg::*;

  localparam int FB_W         = 8;
  localparam int FB_H         = 4;
  localparam int H_VISIBLE    = 10;
  localparam int H_SYNC_START = 10;
  localparam int H_SYNC_END   = 11;
  localparam int H_TOTAL      = 12;
  localparam int V_VISIBLE    = 5;
  localparam int V_SYNC_START = 5;
  localparam int V_SYNC_END   = 6;
  localparam int V_TOTAL      = 6;
  localparam int FRAME_CYC    = H_TOTAL * V_TOTAL;
  // first low vsync shows the sync row at column 0
  localparam int START_OFS    = V_SYNC_START * H_TOTAL;
  localparam int FB_WORDS     = FB_W * FB_H;
  localparam int MEM_WORDS    = 128;
  localparam int MAX_CYCLES   = 2000;

  logic       clk;
  logic       rst_n;
  logic       i_swap;
  logic       i_rnd_wr;
  mem_addr_t  i_rnd_addr;
  mem_word_u  i_rnd_data;
  mem_word_u  i_mem_rdata;
  logic       o_mem_rd;
  logic       o_mem_wr;
  mem_addr_t  o_mem_addr;
  mem_word_u  o_mem_wdata;
  logic       o_rnd_free;
  logic       o_hsync;
  logic       o_vsync;
  logic [3:0] o_pixel;

  logic [3:0] mem [MEM_WORDS];
  logic [3:0] rd_q0;
  logic [3:0] rd_q1;
  logic       prev_rd;

  // trace contents
  int         pre_addr_q [$];
  logic [3:0] pre_word_q [$];
  int         swap_frame_q [$];
  int         rnd_addr_q [$];
  logic [3:0] rnd_data_q [$];
  int         rnd_frame_q [$];
  int         exp_frame_q [$];
  int         exp_x_q [$];
  int         exp_y_q [$];
  logic [3:0] exp_val_q [$];
  bit         exp_seen_q [$];

  // display position once the first vsync is seen
  bit started;
  int cnt;
  int cur_frame;
  int cur_x;
  int cur_y;

  int pix_errs;
  int sync_errs;
  int mem_errs;
  int proto_errs;
  int trace_errs;

  tinygpu_fb_top #(
    .FB_W         (FB_W),
    .FB_H         (FB_H),
    .H_VISIBLE    (H_VISIBLE),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_VISIBLE    (V_VISIBLE),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL),
    .RD_LATENCY   (2)
  ) u_tinygpu_fb_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_swap      (i_swap),
    .i_rnd_wr    (i_rnd_wr),
    .i_rnd_addr  (i_rnd_addr),
    .i_rnd_data  (i_rnd_data),
    .i_mem_rdata (i_mem_rdata),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_rnd_free  (o_rnd_free),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_pixel     (o_pixel)
  );

  always #4 clk = ~clk;

  // background fill is the xor of every address nibble
  function automatic logic [3:0] fill_word(int a);
    logic [3:0] f;
    f = 4'h0;
    for (int i = 0; i < 6; i++) begin
      f = f ^ 4'(a >> (4 * i));
    end
    return f;
  endfunction

  // memory model is loaded while in reset
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(i);
      end
      foreach (pre_addr_q[k]) begin
        mem[7'(pre_addr_q[k])] <= pre_word_q[k];
      end
    end else if (o_mem_wr) begin
      mem[o_mem_addr[6:0]] <= o_mem_wdata;
    end
    rd_q0   <= o_mem_rd ? mem[o_mem_addr[6:0]] : 4'h0;
    rd_q1   <= rd_q0;
    prev_rd <= o_mem_rd;
  end

  // read data lands two cycles after the strobe
  always @(posedge clk) begin
    #1;
    i_mem_rdata = rd_q1;
  end

  // display tracking and pixel checks on the falling edge
  always @(negedge clk) begin
    int   pos;
    logic exp_hs;
    logic exp_vs;
    if (rst_n) begin
      if (!started && !o_vsync) begin
        started = 1'b1;
        cnt     = 0;
      end else if (started) begin
        cnt++;
      end
      if (started) begin
        pos       = (cnt + START_OFS) % FRAME_CYC;
        cur_frame = (cnt + START_OFS) / FRAME_CYC;
        cur_x     = pos % H_TOTAL;
        cur_y     = pos / H_TOTAL;
        // everything outside the buffer is black
        if ((cur_x >= FB_W || cur_y >= FB_H) && o_pixel != 4'h0) begin
          $display("** Error: o_pixel outside buffer at (%0d,%0d): got %h expected %h",
                   cur_x, cur_y, o_pixel, 4'h0);
          pix_errs++;
        end
        // syncs low inside their windows at the pixel's own position
        exp_hs = !(cur_x >= H_SYNC_START && cur_x < H_SYNC_END);
        exp_vs = !(cur_y >= V_SYNC_START && cur_y < V_SYNC_END);
        if (o_hsync != exp_hs) begin
          $display("** Error: o_hsync at (%0d,%0d): got %h expected %h",
                   cur_x, cur_y, o_hsync, exp_hs);
          sync_errs++;
        end
        if (o_vsync != exp_vs) begin
          $display("** Error: o_vsync at (%0d,%0d): got %h expected %h",
                   cur_x, cur_y, o_vsync, exp_vs);
          sync_errs++;
        end
        foreach (exp_frame_q[k]) begin
          if (!exp_seen_q[k] && exp_frame_q[k] == cur_frame && exp_x_q[k] == cur_x &&
              exp_y_q[k] == cur_y) begin
            exp_seen_q[k] = 1'b1;
            if (o_pixel != exp_val_q[k]) begin
              $display("** Error: o_pixel frame %0d at (%0d,%0d): got %h expected %h",
                       cur_frame, cur_x, cur_y, o_pixel, exp_val_q[k]);
              pix_errs++;
            end
          end
        end
      end
      // render window must not overlap a read on the bus
      if (o_rnd_free && (o_mem_rd || prev_rd)) begin
        $display("render window open while a memory read is in flight");
        proto_errs++;
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $finish;
  endtask

  task automatic read_trace();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    int    d;
    string line;
    string rest;
    fd = $fopen("tests/fb_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file");
      trace_errs++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          rest = line.substr(1, line.len() - 1);
          n = $sscanf(rest, "%h %h %h %h", a, b, c, d);
          case (line.getc(0))
            "P": begin
              pre_addr_q.push_back(a);
              pre_word_q.push_back(4'(b));
            end
            "S": swap_frame_q.push_back(a);
            "R": begin
              rnd_addr_q.push_back(a);
              rnd_data_q.push_back(4'(b));
              rnd_frame_q.push_back(c);
            end
            "E": begin
              exp_frame_q.push_back(a);
              exp_x_q.push_back(b);
              exp_y_q.push_back(c);
              exp_val_q.push_back(4'(d));
              exp_seen_q.push_back(1'b0);
            end
            default: begin
              $display("unknown record kind in the trace");
              trace_errs++;
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // idle values of the outputs while held in reset
  task automatic check_reset_state();
    if (o_mem_rd !== 1'b0) begin
      $display("** Error: o_mem_rd in reset: got %h expected %h", o_mem_rd, 1'b0);
      proto_errs++;
    end
    if (o_mem_wr !== 1'b0) begin
      $display("** Error: o_mem_wr in reset: got %h expected %h", o_mem_wr, 1'b0);
      proto_errs++;
    end
    if (o_rnd_free !== 1'b0) begin
      $display("** Error: o_rnd_free in reset: got %h expected %h", o_rnd_free, 1'b0);
      proto_errs++;
    end
    if (o_pixel !== 4'h0) begin
      $display("** Error: o_pixel in reset: got %h expected %h", o_pixel, 4'h0);
      pix_errs++;
    end
    if (o_hsync !== 1'b1) begin
      $display("** Error: o_hsync in reset: got %h expected %h", o_hsync, 1'b1);
      sync_errs++;
    end
    if (o_vsync !== 1'b1) begin
      $display("** Error: o_vsync in reset: got %h expected %h", o_vsync, 1'b1);
      sync_errs++;
    end
  endtask

  // swaps in row 1 of their frame
  // renders once the window is open
  task automatic drive_frames(output bit ok);
    int k;
    int sw_idx;
    int rnd_idx;
    int last_frame;
    last_frame = 0;
    foreach (exp_frame_q[i]) begin
      if (exp_frame_q[i] > last_frame) begin
        last_frame = exp_frame_q[i];
      end
    end
    sw_idx  = 0;
    rnd_idx = 0;
    k       = 0;
    while (cur_frame <= last_frame && k < MAX_CYCLES) begin
      @(posedge clk);
      #1;
      i_swap   = 1'b0;
      i_rnd_wr = 1'b0;
      k++;
      if (sw_idx < swap_frame_q.size() && swap_frame_q[sw_idx] == cur_frame && cur_y == 1) begin
        i_swap = 1'b1;
        sw_idx++;
      end else if (rnd_idx < rnd_frame_q.size() && rnd_frame_q[rnd_idx] <= cur_frame &&
                   o_rnd_free) begin
        i_rnd_wr   = 1'b1;
        i_rnd_addr = mem_addr_t'(rnd_addr_q[rnd_idx]);
        i_rnd_data = rnd_data_q[rnd_idx];
        rnd_idx++;
      end
    end
    @(posedge clk);
    #1;
    i_swap   = 1'b0;
    i_rnd_wr = 1'b0;
    ok = (cur_frame > last_frame);
    if (ok && rnd_idx != rnd_frame_q.size()) begin
      $display("render window never opened for every render write");
      proto_errs++;
    end
  endtask

  // clearer done once the render window reopens
  task automatic wait_clear_done(output bit ok);
    int k;
    k = 0;
    while (!o_rnd_free && k < 1000) begin
      @(posedge clk);
      #1;
      k++;
    end
    ok = o_rnd_free;
    @(posedge clk);
    #1;
  endtask

  task automatic check_memory();
    int back_base;
    int depth_base;
    // old front of the last swap is the cleared back
    back_base  = ((swap_frame_q.size() + 1) % 2) * FB_WORDS;
    depth_base = 2 * FB_WORDS;
    for (int a = 0; a < FB_WORDS; a++) begin
      if (mem[back_base + a] != 4'h0) begin
        $display("** Error: mem[%h] back buffer: got %h expected %h",
                 back_base + a, mem[back_base + a], 4'h0);
        mem_errs++;
      end
      if (mem[depth_base + a] != 4'hF) begin
        $display("** Error: mem[%h] depth: got %h expected %h",
                 depth_base + a, mem[depth_base + a], 4'hF);
        mem_errs++;
      end
    end
    foreach (rnd_addr_q[i]) begin
      if (mem[rnd_addr_q[i]] != rnd_data_q[i]) begin
        $display("** Error: mem[%h] render write: got %h expected %h",
                 rnd_addr_q[i], mem[rnd_addr_q[i]], rnd_data_q[i]);
        mem_errs++;
      end
    end
  endtask

  // hard limit on the whole run
  initial begin
    #50000;
    abort_run("simulation time limit reached");
  end

  initial begin
    int k;
    bit ok;
    clk         = 1'b0;
    rst_n       = 1'b0;
    i_swap      = 1'b0;
    i_rnd_wr    = 1'b0;
    i_rnd_addr  = '0;
    i_rnd_data  = '0;
    i_mem_rdata = '0;
    started     = 1'b0;
    read_trace();
    repeat (10) @(posedge clk);
    #1;
    check_reset_state();
    rst_n = 1'b1;

    // first vertical sync anchors the position count
    k = 0;
    while (!started && k < 500) begin
      @(posedge clk);
      k++;
    end
    if (!started) begin
      abort_run("no vertical sync after reset");
    end else begin
      drive_frames(ok);
      if (!ok) begin
        abort_run("frames did not advance before the cycle limit");
      end else begin
        foreach (exp_seen_q[i]) begin
          if (!exp_seen_q[i]) begin
            $display("expected pixel record %0d was never reached", i);
            pix_errs++;
          end
        end
        wait_clear_done(ok);
        if (!ok) begin
          abort_run("buffer clear did not finish");
        end else begin
          check_memory();
          $display("errors: pixel %0d sync %0d memory %0d protocol %0d trace %0d",
                   pix_errs, sync_errs, mem_errs, proto_errs, trace_errs);
          if (pix_errs == 0 && sync_errs == 0 && mem_errs == 0 && proto_errs == 0 &&
              trace_errs == 0) begin
            $display("test passed");
          end else begin
            $display("test failed");
          end
          $finish;
        end
      end
    end
  end

endmodule

//--- tests/fb_trace.txt
# P addr word : preload, S frame : swap, R addr word frame : render write
# E frame x y value : expected pixel, all fields hex
P 00000a 7
P 000025 6
E 1 0 0 0
E 1 3 1 b
E 1 2 1 7
E 1 5 2 4
E 1 7 3 e
E 1 9 1 0
E 1 2 4 0
S 1
E 2 0 0 2
E 2 4 1 e
E 2 1 2 2
E 2 6 3 d
E 2 5 0 6
R 00000b 9 4
R 000019 5 4
E 5 0 0 2
E 5 7 3 c
S 5
E 6 3 1 9
E 6 1 3 5
E 6 0 0 0
E 6 2 1 0
E 6 7 3 0

//--- files.f
logic/video_timing_pkg.sv
logic/fb_mem_pkg.sv
logic/scan_timer.sv
logic/scanout_reader.sv
logic/buffer_clearer.sv
logic/mem_arbiter.sv
logic/tinygpu_fb_top.sv
tests/tinygpu_fb_chk.sv
tests/tb_tinygpu_fb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_tinygpu_fb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST) tests/fb_trace.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx 'test passed' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
